//--- source/amba_pkg.sv
// APB bus definitions
package amba_pkg;

  // Bus widths of the control port
  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // Slave response codes as carried on pslverr
  localparam logic APB_RESP_OKAY   = 1'b0;
  localparam logic APB_RESP_SLVERR = 1'b1;

  // Read data returned with an error or on a write
  localparam apb_data_t APB_RDATA_NONE = '0;

  // Each region spans 256 bytes, selected above this bit
  localparam int APB_REGION_LSB = 8;
  localparam int APB_REGION_W   = APB_ADDR_W - APB_REGION_LSB;

endpackage

//--- source/soc_map_pkg.sv
// Subsystem address map
package soc_map_pkg;

  // Slave regions
  localparam logic [11:0] PRCI_BASE = 12'h000;
  localparam logic [11:0] GPIO_BASE = 12'h100;

  // Register offsets inside a region
  localparam int OFS_W = 8;
  localparam logic [OFS_W-1:0] PRCI_STATUS_OFS = 8'h00;
  localparam logic [OFS_W-1:0] PRCI_CAUSE_OFS  = 8'h04;
  localparam logic [OFS_W-1:0] PRCI_CTRL_OFS   = 8'h08;
  localparam logic [OFS_W-1:0] GPIO_DIR_OFS    = 8'h00;
  localparam logic [OFS_W-1:0] GPIO_OUT_OFS    = 8'h04;
  localparam logic [OFS_W-1:0] GPIO_IN_OFS     = 8'h08;

  // STATUS bits
  localparam int ST_SYS_LOCK = 0;
  localparam int ST_DDR_LOCK = 1;
  localparam int ST_SYS_RUN  = 2;

  // CAUSE bits stay set until written with 1
  localparam int CAUSE_W        = 3;
  localparam int CAUSE_POR      = 0;
  localparam int CAUSE_SOFT     = 1;
  localparam int CAUSE_LOCKLOSS = 2;

  // CTRL bits
  localparam int CTRL_SOFT_RST = 0;

endpackage

//--- source/reset_sequencer.sv
// System and debug reset sequencer
`timescale 1ns/1ps

module reset_sequencer #(
  parameter int RST_HOLD_CYCLES = 16
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_sys_locked,
  input  logic i_ddr_locked,
  input  logic i_soft_rst_req,
  output logic o_sys_lock_sync,
  output logic o_ddr_lock_sync,
  output logic o_sys_nrst,
  output logic o_dbg_nrst,
  output logic o_ev_por,
  output logic o_ev_soft,
  output logic o_ev_lockloss
);

  localparam int CNT_W = $clog2(RST_HOLD_CYCLES + 1);

  logic [1:0]       por_sync;
  logic [1:0]       sys_lock_sync;
  logic [1:0]       ddr_lock_sync;
  logic [CNT_W-1:0] hold_cnt;
  logic             sys_nrst_q;
  logic             locks_ok;
  logic             run_ok;

  // Power reset release and both lock inputs pass two flops
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      por_sync      <= 2'b00;
      sys_lock_sync <= 2'b00;
      ddr_lock_sync <= 2'b00;
    end else begin
      por_sync      <= {por_sync[0], 1'b1};
      sys_lock_sync <= {sys_lock_sync[0], i_sys_locked};
      ddr_lock_sync <= {ddr_lock_sync[0], i_ddr_locked};
    end
  end

  assign locks_ok = sys_lock_sync[1] & ddr_lock_sync[1];
  assign run_ok   = por_sync[1] & locks_ok;

  // Hold count starts once both locks are seen; any drop starts over
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hold_cnt   <= '0;
      sys_nrst_q <= 1'b0;
    end else if (i_soft_rst_req || !run_ok) begin
      hold_cnt   <= '0;
      sys_nrst_q <= 1'b0;
    end else if (hold_cnt == CNT_W'(RST_HOLD_CYCLES)) begin
      sys_nrst_q <= 1'b1;
    end else begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // Cause pulses with power-on firing on the release edge only
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ev_por      <= 1'b0;
      o_ev_soft     <= 1'b0;
      o_ev_lockloss <= 1'b0;
    end else begin
      o_ev_por      <= por_sync[0] & ~por_sync[1];
      o_ev_soft     <= i_soft_rst_req;
      o_ev_lockloss <= sys_nrst_q & ~locks_ok;
    end
  end

  assign o_sys_lock_sync = sys_lock_sync[1];
  assign o_ddr_lock_sync = ddr_lock_sync[1];
  assign o_sys_nrst      = sys_nrst_q;
  assign o_dbg_nrst      = por_sync[1];

endmodule

//--- source/apb_decoder.sv
// APB region decoder
`timescale 1ns/1ps

module apb_decoder (
  input  logic                i_psel,
  input  logic                i_penable,
  input  amba_pkg::apb_addr_t i_paddr,
  output logic                o_psel_prci,
  output logic                o_psel_gpio,
  input  amba_pkg::apb_data_t i_prdata_prci,
  input  amba_pkg::apb_data_t i_prdata_gpio,
  input  logic                i_pready_prci,
  input  logic                i_pready_gpio,
  input  logic                i_pslverr_prci,
  input  logic                i_pslverr_gpio,
  output amba_pkg::apb_data_t o_prdata,
  output logic                o_pready,
  output logic                o_pslverr
);

  import amba_pkg::*;
  import soc_map_pkg::*;

  logic [APB_REGION_W-1:0] region;
  logic                    hit_prci;
  logic                    hit_gpio;

  assign region   = i_paddr[APB_ADDR_W-1:APB_REGION_LSB];
  assign hit_prci = region == PRCI_BASE[APB_ADDR_W-1:APB_REGION_LSB];
  assign hit_gpio = region == GPIO_BASE[APB_ADDR_W-1:APB_REGION_LSB];

  assign o_psel_prci = i_psel & hit_prci;
  assign o_psel_gpio = i_psel & hit_gpio;

  // Unmapped regions are answered here, in the access cycle
  always_comb begin
    if (hit_prci) begin
      o_prdata  = i_prdata_prci;
      o_pready  = i_pready_prci;
      o_pslverr = i_pslverr_prci;
    end else if (hit_gpio) begin
      o_prdata  = i_prdata_gpio;
      o_pready  = i_pready_gpio;
      o_pslverr = i_pslverr_gpio;
    end else begin
      o_prdata  = APB_RDATA_NONE;
      o_pready  = i_psel & i_penable;
      o_pslverr = (i_psel & i_penable) ? APB_RESP_SLVERR : APB_RESP_OKAY;
    end
  end

endmodule

//--- source/apb_prci.sv
// PRCI register bank
`timescale 1ns/1ps

module apb_prci (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  amba_pkg::apb_addr_t i_paddr,
  input  amba_pkg::apb_data_t i_pwdata,
  output amba_pkg::apb_data_t o_prdata,
  output logic                o_pready,
  output logic                o_pslverr,
  input  logic                i_sys_lock_sync,
  input  logic                i_ddr_lock_sync,
  input  logic                i_sys_nrst,
  input  logic                i_ev_por,
  input  logic                i_ev_soft,
  input  logic                i_ev_lockloss,
  output logic                o_soft_rst_req
);

  import amba_pkg::*;
  import soc_map_pkg::*;

  logic               access;
  logic               wr_en;
  logic               sel_status;
  logic               sel_cause;
  logic               sel_ctrl;
  logic               bad_access;
  logic [CAUSE_W-1:0] cause_q;
  logic [CAUSE_W-1:0] cause_set;
  logic [CAUSE_W-1:0] cause_clr;
  apb_data_t          rdata;

  assign access     = i_psel & i_penable;
  assign sel_status = i_paddr[OFS_W-1:0] == PRCI_STATUS_OFS;
  assign sel_cause  = i_paddr[OFS_W-1:0] == PRCI_CAUSE_OFS;
  assign sel_ctrl   = i_paddr[OFS_W-1:0] == PRCI_CTRL_OFS;
  // STATUS is read-only
  assign bad_access = ~(sel_status | sel_cause | sel_ctrl) | (i_pwrite & sel_status);
  assign wr_en      = access & i_pwrite & ~bad_access;

  always_comb begin
    cause_set                 = '0;
    cause_set[CAUSE_POR]      = i_ev_por;
    cause_set[CAUSE_SOFT]     = i_ev_soft;
    cause_set[CAUSE_LOCKLOSS] = i_ev_lockloss;
  end
  assign cause_clr = (wr_en && sel_cause) ? i_pwdata[CAUSE_W-1:0] : '0;

  // A new event wins over a clear in the same cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cause_q        <= '0;
      o_soft_rst_req <= 1'b0;
    end else begin
      cause_q        <= (cause_q & ~cause_clr) | cause_set;
      o_soft_rst_req <= wr_en & sel_ctrl & i_pwdata[CTRL_SOFT_RST];
    end
  end

  // CTRL reads back as zero
  always_comb begin
    rdata = '0;
    if (sel_status) begin
      rdata[ST_SYS_LOCK] = i_sys_lock_sync;
      rdata[ST_DDR_LOCK] = i_ddr_lock_sync;
      rdata[ST_SYS_RUN]  = i_sys_nrst;
    end else if (sel_cause) begin
      rdata[CAUSE_W-1:0] = cause_q;
    end
  end

  assign o_pready  = access;
  assign o_pslverr = (access && bad_access) ? APB_RESP_SLVERR : APB_RESP_OKAY;
  assign o_prdata  = (access && !i_pwrite && !bad_access) ? rdata : APB_RDATA_NONE;

endmodule

//--- source/apb_gpio.sv
// GPIO register bank
`timescale 1ns/1ps

module apb_gpio #(
  parameter int GPIO_WIDTH = 12
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  amba_pkg::apb_addr_t   i_paddr,
  input  amba_pkg::apb_data_t   i_pwdata,
  output amba_pkg::apb_data_t   o_prdata,
  output logic                  o_pready,
  output logic                  o_pslverr,
  input  logic [GPIO_WIDTH-1:0] i_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio_oe
);

  import amba_pkg::*;
  import soc_map_pkg::*;

  logic                  access;
  logic                  wr_en;
  logic                  sel_dir;
  logic                  sel_out;
  logic                  sel_in;
  logic                  bad_access;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] in_meta;
  logic [GPIO_WIDTH-1:0] in_sync;
  apb_data_t             rdata;

  assign access     = i_psel & i_penable;
  assign sel_dir    = i_paddr[OFS_W-1:0] == GPIO_DIR_OFS;
  assign sel_out    = i_paddr[OFS_W-1:0] == GPIO_OUT_OFS;
  assign sel_in     = i_paddr[OFS_W-1:0] == GPIO_IN_OFS;
  assign bad_access = ~(sel_dir | sel_out | sel_in) | (i_pwrite & sel_in);
  assign wr_en      = access & i_pwrite & ~bad_access;

  // Pins are asynchronous to i_clk
  always_ff @(posedge i_clk) begin
    in_meta <= i_gpio;
    in_sync <= in_meta;
  end

  // All pins come out of reset as inputs
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (wr_en) begin
      if (sel_dir) dir_q <= i_pwdata[GPIO_WIDTH-1:0];
      if (sel_out) out_q <= i_pwdata[GPIO_WIDTH-1:0];
    end
  end

  always_comb begin
    rdata = '0;
    if (sel_dir)
      rdata[GPIO_WIDTH-1:0] = dir_q;
    else if (sel_out)
      rdata[GPIO_WIDTH-1:0] = out_q;
    else if (sel_in)
      rdata[GPIO_WIDTH-1:0] = in_sync;
  end

  assign o_pready  = access;
  assign o_pslverr = (access && bad_access) ? APB_RESP_SLVERR : APB_RESP_OKAY;
  assign o_prdata  = (access && !i_pwrite && !bad_access) ? rdata : APB_RDATA_NONE;
  assign o_gpio    = out_q;
  assign o_gpio_oe = dir_q;

endmodule

//--- source/periph_top.sv
// Peripheral subsystem top
`timescale 1ns/1ps

module periph_top #(
  parameter int GPIO_WIDTH      = 12,
  parameter int RST_HOLD_CYCLES = 16
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  amba_pkg::apb_addr_t   i_paddr,
  input  amba_pkg::apb_data_t   i_pwdata,
  output amba_pkg::apb_data_t   o_prdata,
  output logic                  o_pready,
  output logic                  o_pslverr,
  input  logic                  i_sys_locked,
  input  logic                  i_ddr_locked,
  input  logic [GPIO_WIDTH-1:0] i_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio,
  output logic [GPIO_WIDTH-1:0] o_gpio_oe,
  output logic                  o_sys_nrst,
  output logic                  o_dbg_nrst
);

  import amba_pkg::*;

  logic      psel_prci;
  logic      psel_gpio;
  apb_data_t prdata_prci;
  apb_data_t prdata_gpio;
  logic      pready_prci;
  logic      pready_gpio;
  logic      pslverr_prci;
  logic      pslverr_gpio;
  // Sequencer to PRCI
  logic      sys_lock_sync;
  logic      ddr_lock_sync;
  logic      soft_rst_req;
  logic      ev_por;
  logic      ev_soft;
  logic      ev_lockloss;

  apb_decoder dec0 (
    .i_psel(i_psel), .i_penable(i_penable), .i_paddr(i_paddr),
    .o_psel_prci(psel_prci), .o_psel_gpio(psel_gpio),
    .i_prdata_prci(prdata_prci), .i_prdata_gpio(prdata_gpio),
    .i_pready_prci(pready_prci), .i_pready_gpio(pready_gpio),
    .i_pslverr_prci(pslverr_prci), .i_pslverr_gpio(pslverr_gpio),
    .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr)
  );

  apb_prci prci0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_psel(psel_prci), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .o_prdata(prdata_prci), .o_pready(pready_prci), .o_pslverr(pslverr_prci),
    .i_sys_lock_sync(sys_lock_sync), .i_ddr_lock_sync(ddr_lock_sync),
    .i_sys_nrst(o_sys_nrst),
    .i_ev_por(ev_por), .i_ev_soft(ev_soft), .i_ev_lockloss(ev_lockloss),
    .o_soft_rst_req(soft_rst_req)
  );

  apb_gpio #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) gpio0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_psel(psel_gpio), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .o_prdata(prdata_gpio), .o_pready(pready_gpio), .o_pslverr(pslverr_gpio),
    .i_gpio(i_gpio), .o_gpio(o_gpio), .o_gpio_oe(o_gpio_oe)
  );

  reset_sequencer #(
    .RST_HOLD_CYCLES(RST_HOLD_CYCLES)
  ) rstseq0 (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_sys_locked(i_sys_locked), .i_ddr_locked(i_ddr_locked),
    .i_soft_rst_req(soft_rst_req),
    .o_sys_lock_sync(sys_lock_sync), .o_ddr_lock_sync(ddr_lock_sync),
    .o_sys_nrst(o_sys_nrst), .o_dbg_nrst(o_dbg_nrst),
    .o_ev_por(ev_por), .o_ev_soft(ev_soft), .o_ev_lockloss(ev_lockloss)
  );

endmodule

//--- tb/periph_assertions.sv
// APB response and reset checks
`timescale 1ns/1ps

module periph_assertions (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_psel,
  input logic i_penable,
  input logic i_sys_locked,
  input logic i_ddr_locked,
  input logic i_pready,
  input logic i_pslverr,
  input logic i_sys_nrst,
  input logic i_dbg_nrst
);

  int fail_count = 0;

  err_needs_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pslverr |-> i_pready)
  else begin
    $error("pslverr raised without pready");
    fail_count++;
  end

  ready_in_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pready |-> (i_psel && i_penable))
  else begin
    $error("pready raised outside an access cycle");
    fail_count++;
  end

  // Debug reset never outlives the system reset
  sys_after_dbg: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_sys_nrst |-> i_dbg_nrst)
  else begin
    $error("system reset released while debug reset asserted");
    fail_count++;
  end

  lock_drop_resets: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!i_sys_locked || !i_ddr_locked) [*3] |=> !i_sys_nrst)
  else begin
    $error("system reset still released after lock loss");
    fail_count++;
  end

endmodule

bind periph_top periph_assertions assertions0 (
  .i_clk(i_clk),
  .i_rst_n(i_rst_n),
  .i_psel(i_psel),
  .i_penable(i_penable),
  .i_sys_locked(i_sys_locked),
  .i_ddr_locked(i_ddr_locked),
  .i_pready(o_pready),
  .i_pslverr(o_pslverr),
  .i_sys_nrst(o_sys_nrst),
  .i_dbg_nrst(o_dbg_nrst)
);

//--- tb/tb_periph_top.sv
// Peripheral subsystem testbench
`timescale 1ns/1ps

module tb_periph_top;

  import amba_pkg::*;
  import soc_map_pkg::*;

  localparam int GPIO_WIDTH      = 12;
  localparam int RST_HOLD_CYCLES = 16;
  localparam int CLK_HALF        = 4;
  localparam int SEED            = 9031;
  localparam int N_TESTS         = 6;
  localparam int TIMEOUT_CYCLES  = N_TESTS * 200 + 100;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_psel;
  logic                  i_penable;
  logic                  i_pwrite;
  apb_addr_t             i_paddr;
  apb_data_t             i_pwdata;
  apb_data_t             o_prdata;
  logic                  o_pready;
  logic                  o_pslverr;
  logic                  i_sys_locked;
  logic                  i_ddr_locked;
  logic [GPIO_WIDTH-1:0] i_gpio;
  logic [GPIO_WIDTH-1:0] o_gpio;
  logic [GPIO_WIDTH-1:0] o_gpio_oe;
  logic                  o_sys_nrst;
  logic                  o_dbg_nrst;

  // Register model
  logic [GPIO_WIDTH-1:0] m_dir;
  logic [GPIO_WIDTH-1:0] m_out;
  logic [GPIO_WIDTH-1:0] m_gpio_in;
  logic [CAUSE_W-1:0]    m_cause;
  logic                  m_run;
  int                    errors;

  periph_top #(
    .GPIO_WIDTH(GPIO_WIDTH),
    .RST_HOLD_CYCLES(RST_HOLD_CYCLES)
  ) dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_HALF) i_clk = ~i_clk;
  end

  function automatic logic expected_err(apb_addr_t addr, logic write);
    logic [OFS_W-1:0] ofs;
    ofs = addr[OFS_W-1:0];
    case (addr[11:8])
      PRCI_BASE[11:8]: return !(ofs == PRCI_CAUSE_OFS || ofs == PRCI_CTRL_OFS ||
                                (ofs == PRCI_STATUS_OFS && !write));
      GPIO_BASE[11:8]: return !(ofs == GPIO_DIR_OFS || ofs == GPIO_OUT_OFS ||
                                (ofs == GPIO_IN_OFS && !write));
      default:         return 1'b1;
    endcase
  endfunction

  function automatic apb_data_t expected_read(apb_addr_t addr);
    apb_data_t d;
    d = '0;
    if (expected_err(addr, 1'b0))
      return d;
    if (addr[11:8] == PRCI_BASE[11:8]) begin
      if (addr[OFS_W-1:0] == PRCI_STATUS_OFS) begin
        d[ST_SYS_LOCK] = i_sys_locked;
        d[ST_DDR_LOCK] = i_ddr_locked;
        d[ST_SYS_RUN]  = m_run;
      end else if (addr[OFS_W-1:0] == PRCI_CAUSE_OFS) begin
        d[CAUSE_W-1:0] = m_cause;
      end
    end else begin
      case (addr[OFS_W-1:0])
        GPIO_DIR_OFS: d[GPIO_WIDTH-1:0] = m_dir;
        GPIO_OUT_OFS: d[GPIO_WIDTH-1:0] = m_out;
        default:      d[GPIO_WIDTH-1:0] = m_gpio_in;
      endcase
    end
    return d;
  endfunction

  task automatic check_word(string name, apb_data_t exp, apb_data_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  // Setup then access cycle; response sampled just before the access edge
  task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = write;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(posedge i_clk);
    @(negedge i_clk);
    i_penable = 1'b1;
    #(CLK_HALF - 1);
    rdata = o_prdata;
    err   = o_pslverr;
    check_bit("pready in access cycle", 1'b1, o_pready);
    @(posedge i_clk);
    @(negedge i_clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic apb_write(string name, apb_addr_t addr, apb_data_t data);
    apb_data_t rdata;
    logic      err;
    logic      exp_err;
    exp_err = expected_err(addr, 1'b1);
    apb_transfer(1'b1, addr, data, rdata, err);
    check_bit({name, " pslverr"}, exp_err, err);
    check_word({name, " read data"}, '0, rdata);
    if (!exp_err) begin
      if (addr[11:8] == GPIO_BASE[11:8]) begin
        if (addr[OFS_W-1:0] == GPIO_DIR_OFS) m_dir = data[GPIO_WIDTH-1:0];
        if (addr[OFS_W-1:0] == GPIO_OUT_OFS) m_out = data[GPIO_WIDTH-1:0];
      end else if (addr[OFS_W-1:0] == PRCI_CAUSE_OFS) begin
        m_cause = m_cause & ~data[CAUSE_W-1:0];
      end else if (data[CTRL_SOFT_RST]) begin
        m_cause[CAUSE_SOFT] = 1'b1;
      end
    end
  endtask

  task automatic apb_read(string name, apb_addr_t addr);
    apb_data_t rdata;
    logic      err;
    apb_transfer(1'b0, addr, '0, rdata, err);
    check_word(name, expected_read(addr), rdata);
    check_bit({name, " pslverr"}, expected_err(addr, 1'b0), err);
  endtask

  // Entered half a cycle after the edge that starts the hold count
  task automatic check_release(string name);
    @(negedge i_clk);
    check_bit({name, " reset asserted"}, 1'b0, o_sys_nrst);
    repeat (RST_HOLD_CYCLES) @(negedge i_clk);
    check_bit({name, " reset held"}, 1'b0, o_sys_nrst);
    @(negedge i_clk);
    check_bit({name, " reset released"}, 1'b1, o_sys_nrst);
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge i_clk);
    $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    apb_addr_t addr;
    void'($urandom(SEED));
    errors       = 0;
    i_rst_n      = 1'b0;
    i_psel       = 1'b0;
    i_penable    = 1'b0;
    i_pwrite     = 1'b0;
    i_paddr      = '0;
    i_pwdata     = '0;
    i_sys_locked = 1'b0;
    i_ddr_locked = 1'b0;
    i_gpio       = '0;
    m_dir        = '0;
    m_out        = '0;
    m_gpio_in    = '0;
    m_cause      = '0;
    m_run        = 1'b0;
    repeat (4) @(negedge i_clk);

    // Reset release
    check_bit("pready in reset", 1'b0, o_pready);
    check_bit("pslverr in reset", 1'b0, o_pslverr);
    check_word("gpio pins in reset", '0, apb_data_t'(o_gpio));
    check_word("gpio enables in reset", '0, apb_data_t'(o_gpio_oe));
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check_bit("debug reset held", 1'b0, o_dbg_nrst);
    @(negedge i_clk);
    check_bit("debug reset release", 1'b1, o_dbg_nrst);
    m_cause[CAUSE_POR] = 1'b1;
    repeat (6) @(negedge i_clk);
    check_bit("system reset without locks", 1'b0, o_sys_nrst);
    i_sys_locked = 1'b1;
    i_ddr_locked = 1'b1;
    @(negedge i_clk);
    check_release("power up");
    m_run = 1'b1;
    apb_read("status after power up", PRCI_BASE + PRCI_STATUS_OFS);
    apb_read("cause after power up", PRCI_BASE + PRCI_CAUSE_OFS);

    // GPIO outputs
    for (int k = 0; k < 4; k++) begin
      apb_write("gpio dir write", GPIO_BASE + GPIO_DIR_OFS, $urandom());
      apb_write("gpio out write", GPIO_BASE + GPIO_OUT_OFS, $urandom());
      apb_read("gpio dir read", GPIO_BASE + GPIO_DIR_OFS);
      apb_read("gpio out read", GPIO_BASE + GPIO_OUT_OFS);
      check_word("gpio output pins", apb_data_t'(m_out), apb_data_t'(o_gpio));
      check_word("gpio output enables", apb_data_t'(m_dir), apb_data_t'(o_gpio_oe));
    end

    // GPIO inputs
    for (int k = 0; k < 4; k++) begin
      i_gpio    = GPIO_WIDTH'($urandom());
      m_gpio_in = i_gpio;
      repeat (3) @(negedge i_clk);
      apb_read("gpio in read", GPIO_BASE + GPIO_IN_OFS);
    end

    // Soft reset
    apb_write("ctrl soft reset", PRCI_BASE + PRCI_CTRL_OFS, 32'h1);
    check_release("soft reset");
    apb_read("cause after soft reset", PRCI_BASE + PRCI_CAUSE_OFS);
    apb_write("cause soft clear", PRCI_BASE + PRCI_CAUSE_OFS, 32'h1 << CAUSE_SOFT);
    apb_read("cause after soft clear", PRCI_BASE + PRCI_CAUSE_OFS);

    // Lock loss
    i_ddr_locked = 1'b0;
    repeat (3) @(negedge i_clk);
    check_bit("system reset on lock loss", 1'b0, o_sys_nrst);
    m_run                  = 1'b0;
    m_cause[CAUSE_LOCKLOSS] = 1'b1;
    apb_read("status during lock loss", PRCI_BASE + PRCI_STATUS_OFS);
    apb_read("cause after lock loss", PRCI_BASE + PRCI_CAUSE_OFS);
    i_ddr_locked = 1'b1;
    @(negedge i_clk);
    check_release("lock restore");
    m_run = 1'b1;
    apb_read("status after lock restore", PRCI_BASE + PRCI_STATUS_OFS);
    apb_write("cause lock loss clear", PRCI_BASE + PRCI_CAUSE_OFS, 32'h1 << CAUSE_LOCKLOSS);
    apb_read("cause after lock loss clear", PRCI_BASE + PRCI_CAUSE_OFS);

    // Error responses
    for (int k = 0; k < 4; k++) begin
      addr = {4'($urandom_range(15, 2)), 8'($urandom())};
      apb_read("unmapped region read", addr);
      apb_write("unmapped region write", addr, $urandom());
      addr = {4'($urandom_range(1, 0)), 8'($urandom_range(255, 12))};
      apb_read("unmapped offset read", addr);
      apb_write("unmapped offset write", addr, $urandom());
    end
    apb_write("status write", PRCI_BASE + PRCI_STATUS_OFS, $urandom());
    apb_write("gpio in write", GPIO_BASE + GPIO_IN_OFS, $urandom());
    apb_read("dir after errors", GPIO_BASE + GPIO_DIR_OFS);
    apb_read("out after errors", GPIO_BASE + GPIO_OUT_OFS);
    apb_read("cause after errors", PRCI_BASE + PRCI_CAUSE_OFS);
    apb_read("status after errors", PRCI_BASE + PRCI_STATUS_OFS);

    $display("Checks done: %0d compare errors, %0d assertion failures",
             errors, dut.assertions0.fail_count);
    errors = errors + dut.assertions0.fail_count;
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- periph_subsys.f
source/amba_pkg.sv
source/soc_map_pkg.sv
source/reset_sequencer.sv
source/apb_decoder.sv
source/apb_prci.sv
source/apb_gpio.sv
source/periph_top.sv
tb/periph_assertions.sv
tb/tb_periph_top.sv
